/* Makefile */
# Verilator simulation of the VDP testbench

SIM := obj_dir/Vvdp_tb

all: run

$(SIM): sources.f $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)
	verilator --binary --timing -Wno-fatal --top-module vdp_tb -f sources.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* rtl/vdp_cpu_port.sv */
// VDP CPU bus port
// 68000-style asynchronous bus with synchronized dtack, control and data ports,
// 32 mode registers and the auto-incrementing access pointer
`default_nettype none
`include "vdp_settings.svh"

module vdp_cpu_port import vdp_pkg::*; (
    input  wire         clk96,
    input  wire         rst,
    // main CPU bus
    input  wire  [23:1] addr_i,
    input  wire  [15:0] din_i,
    input  wire         rnw_i,
    input  wire         asn_i,
    input  wire  [ 1:0] dsn_i,
    output logic [15:0] dout_o,
    output logic        dtackn_o,
    // raster status
    input  wire         vblank_i,
    input  wire         hblank_i,
    output logic        video_en_o,
    vdp_mem_if.port     mem
);

    logic [2:0]   strb_s1, strb_s2;   // {asn, dsn[1:0]}
    logic         addr_hit, cs, cs_l, act;
    logic         data_sel, ctrl_sel, tgt_cram;
    logic [7:0]   regs [0:31];
    logic [12:0]  ptr_q;
    vdp_cmd_e     cmd_q;
    vdp_cmd_e     ctrl_cmd;
    vdp_reg_idx_t reg_idx;
    logic         rd_data_q;
    logic [15:0]  status_q;

    assign addr_hit = addr_i[23:4] == `VDP_BASE;
    assign cs       = ~strb_s2[2] & addr_hit;
    assign act      = cs & ~cs_l;           // first cycle of the access only
    assign data_sel = addr_i[3:1] == 3'd0;
    assign ctrl_sel = addr_i[3:1] == 3'd2;
    assign tgt_cram = (cmd_q == CMD_CRAM_RD) || (cmd_q == CMD_CRAM_WR);

    assign ctrl_cmd = vdp_cmd_e'(din_i[15:13]);
    assign reg_idx  = din_i[12:8];

    // memory requests go out combinationally so rdata is ready with dtack
    assign mem.addr   = ptr_q;
    assign mem.wdata  = din_i;
    assign mem.target = tgt_cram;
    assign mem.re     = act & rnw_i & data_sel;
    assign mem.we     = (act & ~rnw_i & data_sel) ? ~strb_s2[1:0] : 2'b00;

    assign video_en_o = regs[1][6];

    always_comb begin
        if (!rd_data_q)
            dout_o = status_q;
        else
            dout_o = mem.rdata;     // color RAM entries arrive zero-extended
    end

    always_ff @(posedge clk96 or posedge rst) begin
        if (rst) begin
            strb_s1   <= 3'b111;
            strb_s2   <= 3'b111;
            cs_l      <= 1'b0;
            dtackn_o  <= 1'b1;
            cmd_q     <= CMD_VRAM_RD;
            ptr_q     <= 13'd0;
            rd_data_q <= 1'b0;
            for (int i = 0; i < 32; i++)
                regs[i] <= 8'd0;
        end else begin
            strb_s1  <= {asn_i, dsn_i};
            strb_s2  <= strb_s1;
            cs_l     <= cs;
            dtackn_o <= ~cs;    // third edge after asn falls
            if (act) begin
                rd_data_q <= data_sel;
                if (data_sel) begin
                    ptr_q <= ptr_q + {5'd0, regs[15]};  // auto-increment
                end else if (ctrl_sel && !rnw_i) begin
                    case (ctrl_cmd)
                        CMD_REG_WR: regs[reg_idx] <= din_i[7:0];
                        CMD_VRAM_RD, CMD_VRAM_WR, CMD_CRAM_RD, CMD_CRAM_WR: begin
                            cmd_q <= ctrl_cmd;
                            ptr_q <= din_i[12:0];
                        end
                        default: ;  // unused codes
                    endcase
                end
            end
        end
    end

    // status word, bit 3 vblank, bit 2 hblank
    always_ff @(posedge clk96) begin
        if (act && ctrl_sel && rnw_i)
            status_q <= {12'd0, vblank_i, hblank_i, 2'b00};
    end

endmodule

`default_nettype wire

/* rtl/vdp_mem_if.sv */
// VDP memory access bus
// carries CPU reads and writes from the bus port into VRAM and color RAM
`default_nettype none

interface vdp_mem_if;
    logic [12:0] addr;     // word address from the pointer
    logic [15:0] wdata;
    logic        target;   // 0 VRAM, 1 color RAM
    logic [ 1:0] we;       // per byte, bit 1 is the upper byte
    logic        re;
    logic [15:0] rdata;    // valid one cycle after re

    modport port (
        output addr, wdata, target, we, re,
        input  rdata
    );

    modport mem (
        input  addr, wdata, target, we, re,
        output rdata
    );
endinterface

`default_nettype wire

/* rtl/vdp_pixel_clock.sv */
// VDP pixel clock enable
// 12 MHz (8 cycles) for most of the line, 16 MHz (6 cycles) in the fast window
`default_nettype none

module vdp_pixel_clock (
    input  wire  clk96,
    input  wire  rst,
    input  wire  fast_i,     // current pixel is in the fast window
    output logic pxl_cen_o
);

    logic [2:0] cnt;
    logic [2:0] reload;

    // the period of the next pixel follows the current one
    assign reload = fast_i ? 3'd5 : 3'd7;

    always_ff @(posedge clk96 or posedge rst) begin
        if (rst) begin
            cnt       <= 3'd0;
            pxl_cen_o <= 1'b0;
        end else begin
            if (cnt == 3'd0) begin
                cnt       <= reload;
                pxl_cen_o <= 1'b1;  // one pulse per reload
            end else begin
                cnt       <= cnt - 3'd1;
                pxl_cen_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/vdp_pkg.sv */
// VDP shared types
// command codes of the control port, palette entry layout, register index
`default_nettype none

package vdp_pkg;

    // top three bits of a control word
    typedef enum logic [2:0] {
        CMD_VRAM_RD = 3'b000,
        CMD_VRAM_WR = 3'b001,
        CMD_CRAM_RD = 3'b010,
        CMD_CRAM_WR = 3'b011,
        CMD_REG_WR  = 3'b100
    } vdp_cmd_e;

    // one color RAM entry, 3 bits per channel
    typedef struct packed {
        logic [2:0] blue;
        logic [2:0] green;
        logic [2:0] red;
    } vdp_color_t;

    typedef logic [4:0] vdp_reg_idx_t;  // 32 mode registers

endpackage

`default_nettype wire

/* rtl/vdp_raster.sv */
// VDP raster timing and pixel path
// pixel and line counters, sync and enables, block map fetch and palette to RGB
`default_nettype none
`include "vdp_settings.svh"

module vdp_raster import vdp_pkg::*; (
    input  wire                 clk96,
    input  wire                 rst,
    input  wire                 pxl_cen_i,
    input  wire                 video_en_i,
    output logic                fast_o,
    output logic [`VRAM_AW-1:0] map_addr_o,
    input  wire  [15:0]         map_word_i,
    output logic [`CRAM_AW-1:0] cram_idx_o,
    input  wire  [8:0]          cram_color_i,
    output logic                hs_o,
    output logic                vs_o,
    output logic                hde_o,
    output logic                vde_o,
    output logic [7:0]          red_o,
    output logic [7:0]          green_o,
    output logic [7:0]          blue_o,
    output logic                vblank_o,
    output logic                hblank_o
);

    logic [8:0] h_cnt, v_cnt;
    logic       h_act, v_act, hs_raw, vs_raw;
    logic [3:0] sync_d1;     // {hs, vs, hde, vde} one pixel behind
    vdp_color_t pal_in, pal_q;

    function automatic logic [7:0] widen(input logic [2:0] c);
        widen = {c, c, c[2:1]};
    endfunction

    assign h_act  = h_cnt < `H_ACTIVE;
    assign v_act  = v_cnt < `V_ACTIVE;
    assign hs_raw = (h_cnt >= `HS_START) && (h_cnt < `HS_END);
    assign vs_raw = (v_cnt >= `VS_START) && (v_cnt < `VS_END);
    assign fast_o = (h_cnt >= `H_FAST_START) && (h_cnt < `H_FAST_END);

    assign hblank_o = ~h_act;
    assign vblank_o = ~v_act;

    // 32x32 block map, one word per 16x8 pixel block
    assign map_addr_o = {1'b0, v_cnt[7:3], h_cnt[8:4]};
    assign cram_idx_o = map_word_i[3:0];
    assign pal_in     = cram_color_i;

    always_ff @(posedge clk96 or posedge rst) begin
        if (rst) begin
            h_cnt   <= 9'd0;
            v_cnt   <= 9'd0;
            sync_d1 <= 4'd0;
            {hs_o, vs_o, hde_o, vde_o} <= 4'd0;
            {red_o, green_o, blue_o}   <= 24'd0;
        end else if (pxl_cen_i) begin
            if (h_cnt == `H_TOTAL - 1) begin
                h_cnt <= 9'd0;
                v_cnt <= (v_cnt == `V_TOTAL - 1) ? 9'd0 : v_cnt + 9'd1;
            end else begin
                h_cnt <= h_cnt + 9'd1;
            end
            sync_d1 <= {hs_raw, vs_raw, h_act, v_act};
            {hs_o, vs_o, hde_o, vde_o} <= sync_d1;
            if (sync_d1[1] && sync_d1[0] && video_en_i) begin
                red_o   <= widen(pal_q.red);
                green_o <= widen(pal_q.green);
                blue_o  <= widen(pal_q.blue);
            end else begin
                {red_o, green_o, blue_o} <= 24'd0;  // blanked
            end
        end
    end

    // palette entry settles within two clk96 cycles of the pixel enable
    always_ff @(posedge clk96) begin
        if (pxl_cen_i)
            pal_q <= pal_in;
    end

endmodule

`default_nettype wire

/* rtl/vdp_settings.svh */
// VDP build constants
// bus window, memory depths and raster geometry shared by RTL and testbench
`ifndef VDP_SETTINGS_SVH
`define VDP_SETTINGS_SVH

// chip select, compared with addr[23:4]
`define VDP_BASE        20'hC0000

`define VRAM_AW         11      // 2048 words of 16 bits
`define CRAM_AW         4       // 16 palette entries

// horizontal geometry, in pixels
`define H_TOTAL         342
`define H_ACTIVE        320
`define H_FAST_START    280     // 16 MHz pixels from here
`define H_FAST_END      342     // up to the end of the line
`define HS_START        290
`define HS_END          316

// vertical geometry, in lines
`define V_TOTAL         262
`define V_ACTIVE        224
`define VS_START        234
`define VS_END          237

`endif

/* rtl/vdp_top.sv */
// VDP top level
// CPU port, video memories, raster and pixel clock on a 96 MHz clock
`default_nettype none
`include "vdp_settings.svh"

module vdp_top import vdp_pkg::*; (
    input  wire         clk96,
    input  wire         rst,
    // main CPU bus
    input  wire  [23:1] addr_i,
    input  wire  [15:0] din_i,
    input  wire         rnw_i,
    input  wire         asn_i,
    input  wire  [ 1:0] dsn_i,
    output logic [15:0] dout_o,
    output logic        dtackn_o,
    // video
    output logic        video_en_o,
    output logic        pxl_cen_o,
    output logic        hs_o,
    output logic        vs_o,
    output logic        hde_o,
    output logic        vde_o,
    output logic [ 7:0] red_o,
    output logic [ 7:0] green_o,
    output logic [ 7:0] blue_o
);

    logic                fast;
    logic                vblank, hblank;
    logic [`VRAM_AW-1:0] map_addr;
    logic [15:0]         map_word;
    logic [`CRAM_AW-1:0] cram_idx;
    vdp_color_t          cram_color;

    vdp_mem_if mem_bus ();

    vdp_cpu_port u_cpu_port (
        .clk96      ( clk96      ),
        .rst        ( rst        ),
        .addr_i     ( addr_i     ),
        .din_i      ( din_i      ),
        .rnw_i      ( rnw_i      ),
        .asn_i      ( asn_i      ),
        .dsn_i      ( dsn_i      ),
        .dout_o     ( dout_o     ),
        .dtackn_o   ( dtackn_o   ),
        .vblank_i   ( vblank     ),
        .hblank_i   ( hblank     ),
        .video_en_o ( video_en_o ),
        .mem        ( mem_bus    )
    );

    vdp_vram u_vram (
        .clk96        ( clk96      ),
        .mem          ( mem_bus    ),
        .map_addr_i   ( map_addr   ),
        .map_word_o   ( map_word   ),
        .cram_idx_i   ( cram_idx   ),
        .cram_color_o ( cram_color )
    );

    vdp_raster u_raster (
        .clk96        ( clk96      ),
        .rst          ( rst        ),
        .pxl_cen_i    ( pxl_cen_o  ),
        .video_en_i   ( video_en_o ),
        .fast_o       ( fast       ),
        .map_addr_o   ( map_addr   ),
        .map_word_i   ( map_word   ),
        .cram_idx_o   ( cram_idx   ),
        .cram_color_i ( cram_color ),
        .hs_o         ( hs_o       ),
        .vs_o         ( vs_o       ),
        .hde_o        ( hde_o      ),
        .vde_o        ( vde_o      ),
        .red_o        ( red_o      ),
        .green_o      ( green_o    ),
        .blue_o       ( blue_o     ),
        .vblank_o     ( vblank     ),
        .hblank_o     ( hblank     )
    );

    vdp_pixel_clock u_pixel_clock (
        .clk96     ( clk96     ),
        .rst       ( rst       ),
        .fast_i    ( fast      ),
        .pxl_cen_o ( pxl_cen_o )
    );

endmodule

`default_nettype wire

/* rtl/vdp_vram.sv */
// VDP video memories
// VRAM and color RAM, each with a CPU port and a raster read port,
// all reads registered
`default_nettype none
`include "vdp_settings.svh"

module vdp_vram import vdp_pkg::*; (
    input  wire                 clk96,
    vdp_mem_if.mem              mem,
    input  wire [`VRAM_AW-1:0]  map_addr_i,
    output logic [15:0]         map_word_o,
    input  wire [`CRAM_AW-1:0]  cram_idx_i,
    output vdp_color_t          cram_color_o
);

    logic [15:0] vram [0:(1 << `VRAM_AW) - 1];
    vdp_color_t  cram [0:(1 << `CRAM_AW) - 1];

    logic [`VRAM_AW-1:0] cpu_vaddr;
    logic [`CRAM_AW-1:0] cpu_caddr;

    assign cpu_vaddr = mem.addr[`VRAM_AW-1:0];
    assign cpu_caddr = mem.addr[`CRAM_AW-1:0];

    // CPU side
    always_ff @(posedge clk96) begin
        if (!mem.target) begin
            if (mem.we[0])
                vram[cpu_vaddr][7:0] <= mem.wdata[7:0];
            if (mem.we[1])
                vram[cpu_vaddr][15:8] <= mem.wdata[15:8];
        end else if (|mem.we) begin
            cram[cpu_caddr] <= mem.wdata[8:0];  // low byte plus bit 8
        end
        if (mem.re)
            mem.rdata <= mem.target ? {7'd0, cram[cpu_caddr]} : vram[cpu_vaddr];
    end

    // raster side, sees the old word on a same-cycle write
    always_ff @(posedge clk96) begin
        map_word_o   <= vram[map_addr_i];
        cram_color_o <= cram[cram_idx_i];
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
rtl/vdp_pkg.sv
rtl/vdp_mem_if.sv
rtl/vdp_pixel_clock.sv
rtl/vdp_cpu_port.sv
rtl/vdp_vram.sv
rtl/vdp_raster.sv
rtl/vdp_top.sv
verification/tb_clock.sv
verification/vdp_tb.sv

/* verification/tb_clock.sv */
// testbench clock and reset
// free-running clock, active-high reset held for a number of cycles
`default_nettype none

module tb_clock #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #10;
        rst_o = 1'b0;   // released just after an edge
    end

endmodule

`default_nettype wire

/* verification/vdp_tb.sv */
// VDP testbench
// bus round trips, register control, line and frame timing and the pixel path of vdp_top
`default_nettype none
`include "vdp_settings.svh"

module vdp_tb;

    typedef enum int {OP_CTRL_WR, OP_DATA_WR, OP_DATA_RD, OP_STAT_RD} op_kind_e;
    typedef struct {
        op_kind_e    kind;
        int          tst;
        logic [2:0]  off;   // word offset in the chip window
        logic [1:0]  dsn;
        logic [15:0] data;
        logic [15:0] exp;
    } op_t;

    // 8 clk96 cycles per slow pixel, 6 per fast one
    localparam int LINE_CYC  = `H_FAST_START * 8 + (`H_TOTAL - `H_FAST_START) * 6;
    localparam int FRAME_CYC = `V_TOTAL * LINE_CYC;

    logic        clk96, rst, rnw, asn, dtackn, video_en, pxl_cen, hs, vs, hde, vde;
    logic [23:1] addr;
    logic [15:0] din, dout;
    logic [1:0]  dsn;
    logic [7:0]  red, green, blue;
    op_t         ops[$];
    logic [31:0] lfsr = 32'he750_3b5f;
    int          cyc = 0, cycle_limit = 0, errors = 0;
    int          tests_run = 0, tests_failed = 0, err_mark = 0;

    tb_clock #(.PERIOD(100), .RST_CYCLES(10)) u_clock (.clk_o(clk96), .rst_o(rst));

    vdp_top uut (
        .clk96(clk96), .rst(rst), .addr_i(addr), .din_i(din), .rnw_i(rnw), .asn_i(asn),
        .dsn_i(dsn), .dout_o(dout), .dtackn_o(dtackn), .video_en_o(video_en),
        .pxl_cen_o(pxl_cen), .hs_o(hs), .vs_o(vs), .hde_o(hde), .vde_o(vde),
        .red_o(red), .green_o(green), .blue_o(blue)
    );

    always @(posedge clk96) begin
        cyc = cyc + 1;
        if (cyc > cycle_limit) begin
            $display("ERROR: the run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic        fb;
        v = 16'd0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[14:0], fb};
        end
        return v;
    endfunction

    function automatic logic [7:0] expand3(input logic [2:0] c);
        return {c, c, c[2:1]};  // bits repeated from the top
    endfunction

    function automatic void add_op(input op_kind_e kind, input int tst, input logic [1:0] strb,
                                   input logic [15:0] data, input logic [15:0] exp);
        op_t op;
        op.kind = kind;
        op.tst  = tst;
        op.off  = (kind == OP_CTRL_WR || kind == OP_STAT_RD) ? 3'd2 : 3'd0;
        op.dsn  = strb;
        op.data = data;
        op.exp  = exp;
        ops.push_back(op);
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic report_error(input string what);
        $display("ERROR %0t %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // one CPU access, asn held until dtackn falls
    task automatic bus_access(input logic [2:0] off, input logic rd, input logic [1:0] strb,
                              input logic [15:0] wdata, output logic [15:0] rdata);
        int n;
        @(posedge clk96);
        #10;
        addr = {`VDP_BASE, off};
        rnw  = rd;
        dsn  = strb;
        din  = wdata;
        asn  = 1'b0;
        n    = 0;
        do begin
            @(posedge clk96);
            #1;
            n++;
        end while (dtackn && n < 20);
        if (dtackn) report_error("dtackn_o never fell during a bus access");
        else if (n != 3) report_value("dtack latency", 3, n);
        rdata = dout;
        #9;
        asn = 1'b1;
        dsn = 2'b11;
        n   = 0;
        do begin
            @(posedge clk96);
            #1;
            n++;
        end while (!dtackn && n < 20);
        if (!dtackn) report_error("dtackn_o stayed low after asn was raised");
    endtask

    task automatic run_table(input int tst);
        logic [15:0] rdata;
        foreach (ops[i]) begin
            if (ops[i].tst == tst) begin
                bus_access(ops[i].off, ops[i].kind == OP_DATA_RD || ops[i].kind == OP_STAT_RD,
                           ops[i].dsn, ops[i].data, rdata);
                if (ops[i].kind == OP_DATA_RD && rdata !== ops[i].exp)
                    report_value("dout_o", ops[i].exp, rdata);
                if (ops[i].kind == OP_STAT_RD && (rdata & 16'h0008) !== ops[i].exp)
                    report_value("dout_o[3]", ops[i].exp, rdata & 16'h0008);
            end
        end
    endtask

    // cycle count at the next rising edge of hs (sel 0) or vs (sel 1)
    task automatic wait_rise(input logic sel, output int at);
        logic prev, cur, found;
        prev  = sel ? vs : hs;
        found = 1'b0;
        while (!found) begin
            @(posedge clk96);
            #1;
            cur   = sel ? vs : hs;
            found = cur && !prev;
            prev  = cur;
        end
        at = cyc;
    endtask

    initial begin
        logic [15:0] vram_words [8];
        logic [15:0] cram_words [16];
        logic [15:0] b, rdata;
        logic [8:0]  color;
        logic [23:0] want;
        int          t0, t1, t2, n, pixels, enables;
        logic        stop;
        asn  = 1'b1;
        dsn  = 2'b11;
        rnw  = 1'b1;
        addr = '0;
        din  = '0;
        for (int i = 0; i < 8; i++) vram_words[i] = rand_bits(16);
        for (int i = 0; i < 16; i++) cram_words[i] = rand_bits(16);
        b = rand_bits(16);
        add_op(OP_CTRL_WR, 2, 2'b00, 16'h8F01, 16'h0);     // auto-increment 1
        add_op(OP_CTRL_WR, 2, 2'b00, 16'h2100, 16'h0);
        for (int i = 0; i < 8; i++) add_op(OP_DATA_WR, 2, 2'b00, vram_words[i], 16'h0);
        add_op(OP_CTRL_WR, 2, 2'b00, 16'h0100, 16'h0);
        for (int i = 0; i < 8; i++) add_op(OP_DATA_RD, 2, 2'b00, 16'h0, vram_words[i]);
        add_op(OP_CTRL_WR, 2, 2'b00, 16'h2103, 16'h0);
        add_op(OP_DATA_WR, 2, 2'b10, b, 16'h0);            // low byte only
        add_op(OP_CTRL_WR, 2, 2'b00, 16'h0103, 16'h0);
        add_op(OP_DATA_RD, 2, 2'b00, 16'h0, {vram_words[3][15:8], b[7:0]});
        add_op(OP_CTRL_WR, 3, 2'b00, 16'h6000, 16'h0);
        for (int i = 0; i < 16; i++) add_op(OP_DATA_WR, 3, 2'b00, cram_words[i], 16'h0);
        add_op(OP_CTRL_WR, 3, 2'b00, 16'h4000, 16'h0);
        for (int i = 0; i < 16; i++)
            add_op(OP_DATA_RD, 3, 2'b00, 16'h0, {7'd0, cram_words[i][8:0]});
        add_op(OP_CTRL_WR, 4, 2'b00, 16'h0101, 16'h0);
        add_op(OP_CTRL_WR, 4, 2'b00, 16'hE000, 16'h0);     // unused code
        add_op(OP_DATA_RD, 4, 2'b00, 16'h0, vram_words[1]);
        add_op(OP_STAT_RD, 5, 2'b00, 16'h0, 16'h0008);     // vblank, read during vs
        cycle_limit = 3 * FRAME_CYC + 4000 * ops.size();

        @(negedge rst);
        @(posedge clk96);
        #1;
        if (dtackn !== 1'b1) report_value("dtackn_o", 1, dtackn);
        if (video_en !== 1'b0) report_value("video_en_o", 0, video_en);
        if (hs !== 1'b0) report_value("hs_o", 0, hs);
        if (vs !== 1'b0) report_value("vs_o", 0, vs);
        if ({red, green, blue} !== 24'd0) report_value("rgb", 0, {red, green, blue});
        finish_test("reset state");
        run_table(2);
        finish_test("VRAM round trip");
        run_table(3);
        finish_test("color RAM round trip");

        bus_access(3'd2, 1'b0, 2'b00, 16'h8140, rdata);
        if (video_en !== 1'b1) report_value("video_en_o", 1, video_en);
        bus_access(3'd2, 1'b0, 2'b00, 16'h8100, rdata);
        if (video_en !== 1'b0) report_value("video_en_o", 0, video_en);
        run_table(4);
        finish_test("register control");

        wait_rise(1'b1, t0);
        wait_rise(1'b0, t1);
        wait_rise(1'b0, t2);
        if (t2 - t1 != LINE_CYC) report_value("hs_o period", LINE_CYC, t2 - t1);
        if (vde) report_error("vde_o was still high at the status read");
        run_table(5);
        wait_rise(1'b1, t1);
        if (t1 - t0 != FRAME_CYC) report_value("vs_o period", FRAME_CYC, t1 - t0);
        finish_test("line and frame timing");

        color = rand_bits(9);
        want  = {expand3(color[2:0]), expand3(color[5:3]), expand3(color[8:6])};
        bus_access(3'd2, 1'b0, 2'b00, 16'h2000, rdata);    // map from word 0
        for (int i = 0; i < 1024; i++) bus_access(3'd0, 1'b0, 2'b00, 16'h0005, rdata);
        bus_access(3'd2, 1'b0, 2'b00, 16'h6005, rdata);
        bus_access(3'd0, 1'b0, 2'b00, {7'd0, color}, rdata);
        bus_access(3'd2, 1'b0, 2'b00, 16'h8140, rdata);
        n = 0;
        while (n < 3) begin   // let the two memory stages catch up
            @(posedge clk96);
            #1;
            if (pxl_cen) n++;
        end
        pixels  = 0;
        enables = 0;
        stop    = 1'b0;
        t0      = cyc;
        while (!stop && cyc - t0 < FRAME_CYC) begin
            @(posedge clk96);
            #1;
            if (pxl_cen) enables++;
            if (pxl_cen && hde && vde) begin
                pixels++;
                if ({red, green, blue} !== want) begin
                    report_value("rgb", want, {red, green, blue});
                    stop = 1'b1;
                end
            end else if (pxl_cen && {red, green, blue} !== 24'd0) begin
                report_value("rgb", 0, {red, green, blue});
                stop = 1'b1;
            end
        end
        // one whole frame of pixel enables was watched
        if (!stop) begin
            if (enables != `H_TOTAL * `V_TOTAL)
                report_value("pxl_cen_o count", `H_TOTAL * `V_TOTAL, enables);
            if (pixels != `H_ACTIVE * `V_ACTIVE)
                report_value("hde_o and vde_o count", `H_ACTIVE * `V_ACTIVE, pixels);
        end
        finish_test("pixel path");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
